// File: fir_afu.f
verilog/fir_host_pkg.sv
verilog/fir_pkg.sv
verilog/fir_csr.sv
verilog/fir_fifo.sv
verilog/fir_fetch.sv
verilog/fir_filter.sv
verilog/fir_store.sv
verilog/fir_afu.sv
verif/tb_clock.sv
verif/fir_props.sv
verif/fir_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = fir_tb
FILELIST = fir_afu.f
OBJ_DIR  = obj_dir
RUN_ARGS = +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, and look for the pass message"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	  echo "$$out"; \
	  echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/fir_tb.sv
// Host memory holds 4096 lines, addressed by the low 12 bits of the line address
`timescale 1ns/100ps

module fir_tb;
  import fir_host_pkg::*;
  import fir_pkg::*;

  localparam int MEM_LINES  = 4096;
  localparam int JOB1_LINES = 12;
  localparam int JOB2_LINES = 7;
  localparam int IN1_LINE   = 'h100;
  localparam int OUT1_LINE  = 'h200;
  localparam int IN2_LINE   = 'h140;
  localparam int OUT2_LINE  = 'h240;
  localparam int DSM_LINE   = 'h300;
  localparam int TIMEOUT_CYCLES = 2000 + 40 * (JOB1_LINES + JOB2_LINES);

  logic       clk;
  logic       reset;
  logic       mmio_rd_valid;
  logic       mmio_wr_valid;
  t_mmio_addr mmio_addr;
  t_tid       mmio_tid;
  t_mmio_data mmio_wdata;
  logic       mmio_rsp_valid;
  t_tid       mmio_rsp_tid;
  t_mmio_data mmio_rsp_data;
  logic       rd_req_valid;
  t_line_addr rd_req_addr;
  logic       rd_alm_full;
  logic       rd_rsp_valid;
  t_line_data rd_rsp_data;
  logic       wr_req_valid;
  t_line_addr wr_req_addr;
  t_line_data wr_req_data;
  logic       wr_alm_full;
  logic       wr_rsp_valid;

  t_line_data  mem [MEM_LINES];
  t_line_data  expected [MEM_LINES];
  t_line_addr  rd_addr_q [$];
  int unsigned rd_due_q [$];
  int unsigned ack_due_q [$];
  int unsigned last_due;
  int unsigned cyc;
  int          error_count;
  int          prop_errors;
  logic [15:0] lfsr_state = 16'd7;

  tb_clock u_clock (.clk);

  fir_afu DUT (
    .clk, .reset,
    .mmio_rd_valid, .mmio_wr_valid, .mmio_addr, .mmio_tid, .mmio_wdata,
    .mmio_rsp_valid, .mmio_rsp_tid, .mmio_rsp_data,
    .rd_req_valid, .rd_req_addr, .rd_alm_full, .rd_rsp_valid, .rd_rsp_data,
    .wr_req_valid, .wr_req_addr, .wr_req_data, .wr_alm_full, .wr_rsp_valid
  );

  bind fir_afu fir_props u_props (
    .clk, .reset,
    .mmio_rd_valid, .mmio_addr, .mmio_tid, .mmio_rsp_valid, .mmio_rsp_tid,
    .rd_req_valid, .rd_req_addr, .rd_alm_full,
    .wr_req_valid, .wr_req_addr, .wr_req_data, .wr_alm_full,
    .job_start,
    .in_addr  (hc_buffer[0].address),
    .in_size  (hc_buffer[0].size),
    .out_size (hc_buffer[1].size),
    .dsm_base (hc_dsm_base)
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr_bit()};
    end
    return v;
  endfunction

  // Random input lines and the reference output of a fresh job
  task automatic prepare_job(input int in_line, input int out_line, input int n);
    t_sample    stream [$];
    t_line_data word;
    t_line_data want;
    longint     acc;
    int         p;
    // Three zero samples stand for the cleared history
    stream = '{16'sd0, 16'sd0, 16'sd0};
    for (int j = 0; j < n; j++) begin
      word = rand_bits(64);
      mem[in_line + j] = word;
      mem[out_line + j] = '0;
      for (int m = 0; m < SAMPLES_PER_LINE; m++) begin
        stream.push_back(t_sample'(word[16*m +: 16]));
      end
      for (int m = 0; m < SAMPLES_PER_LINE; m++) begin
        p = FIR_TAPS - 1 + SAMPLES_PER_LINE * j + m;
        acc = 0;
        for (int k = 0; k < FIR_TAPS; k++) begin
          acc += longint'(FIR_COEFF[k]) * longint'(stream[p - k]);
        end
        want[16*m +: 16] = 16'(acc >>> FIR_SHIFT);
      end
      expected[out_line + j] = want;
    end
  endtask

  task automatic mmio_write(input t_mmio_addr addr, input t_mmio_data data);
    @(posedge clk);
    #2;
    mmio_wr_valid = 1'b1;
    mmio_addr     = addr;
    mmio_wdata    = data;
    @(posedge clk);
    #2;
    mmio_wr_valid = 1'b0;
  endtask

  task automatic mmio_read_check(input t_mmio_addr addr, input t_tid tid,
                                 input t_mmio_data want);
    bit seen;
    seen = 1'b0;
    @(posedge clk);
    #2;
    mmio_rd_valid = 1'b1;
    mmio_addr     = addr;
    mmio_tid      = tid;
    @(posedge clk);
    #2;
    mmio_rd_valid = 1'b0;
    for (int i = 0; i < 4 && !seen; i++) begin
      @(negedge clk);
      if (mmio_rsp_valid) begin
        seen = 1'b1;
        assert (mmio_rsp_data == want) else begin
          $display("mismatch mmio_rsp_data: got %h expected %h", mmio_rsp_data, want);
          error_count++;
        end
        assert (mmio_rsp_tid == tid) else begin
          $display("mismatch mmio_rsp_tid: got %h expected %h", mmio_rsp_tid, tid);
          error_count++;
        end
      end
    end
    assert (seen) else begin
      $display("no MMIO response to the read of word address %h", addr);
      error_count++;
    end
  endtask

  task automatic check_job(input int out_line, input int n);
    for (int j = 0; j < n; j++) begin
      assert (mem[out_line + j] == expected[out_line + j]) else begin
        $display("mismatch wr_req_data at line %h: got %h expected %h",
                 out_line + j, mem[out_line + j], expected[out_line + j]);
        error_count++;
      end
    end
  endtask

  task automatic run_job(input int in_line, input int out_line, input int n);
    mem[DSM_LINE] = '0;
    mmio_write(BUFFER_ADDR_BASE, 64'(in_line) << 6);
    mmio_write(BUFFER_ADDR_BASE + 16'd2, 64'(n) << 6);
    mmio_write(BUFFER_ADDR_BASE + 16'd4, 64'(out_line) << 6);
    mmio_write(BUFFER_ADDR_BASE + 16'd6, 64'(n) << 6);
    mmio_write(CONTROL_ADDR, 64'd1);
    while (mem[DSM_LINE] != DONE_WORD) begin
      @(posedge clk);
    end
    // Completion write must be acknowledged before run drops
    while (ack_due_q.size() != 0) begin
      @(posedge clk);
    end
    mmio_write(CONTROL_ADDR, 64'd0);
    check_job(out_line, n);
  endtask

  // Host side responses and back-pressure, driven after the edge
  always @(posedge clk) begin : drive_host
    t_line_addr addr;
    #2;
    cyc = cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("timeout: job not complete after %0d cycles", TIMEOUT_CYCLES);
      $display("ERRORS FOUND");
      $finish;
    end else begin
      // Each level high about a quarter of the time
      rd_alm_full  = (rand_bits(2) == '0);
      wr_alm_full  = (rand_bits(2) == '0);
      rd_rsp_valid = 1'b0;
      wr_rsp_valid = 1'b0;
      if (rd_due_q.size() != 0 && rd_due_q[0] <= cyc) begin
        void'(rd_due_q.pop_front());
        addr         = rd_addr_q.pop_front();
        rd_rsp_valid = 1'b1;
        rd_rsp_data  = mem[addr[11:0]];
      end
      if (ack_due_q.size() != 0 && ack_due_q[0] <= cyc) begin
        void'(ack_due_q.pop_front());
        wr_rsp_valid = 1'b1;
      end
    end
  end

  // Requests sampled mid-cycle, once settled
  always @(negedge clk) begin : sample_requests
    int unsigned due;
    if (rd_req_valid) begin
      due = cyc + 1 + int'(rand_bits(2));
      // Keeps responses in request order
      if (due <= last_due)
        due = last_due + 1;
      last_due = due;
      rd_addr_q.push_back(rd_req_addr);
      rd_due_q.push_back(due);
    end
    if (wr_req_valid) begin
      mem[wr_req_addr[11:0]] = wr_req_data;
      ack_due_q.push_back(cyc + 1);
    end
  end

  initial begin
    reset         = 1'b1;
    mmio_rd_valid = 1'b0;
    mmio_wr_valid = 1'b0;
    mmio_addr     = '0;
    mmio_tid      = '0;
    mmio_wdata    = '0;
    rd_alm_full   = 1'b0;
    wr_alm_full   = 1'b0;
    rd_rsp_valid  = 1'b0;
    rd_rsp_data   = '0;
    wr_rsp_valid  = 1'b0;
    cyc           = 0;
    last_due      = 0;
    error_count   = 0;
    for (int i = 0; i < MEM_LINES; i++) begin
      mem[i]      = '0;
      expected[i] = '0;
    end
    prepare_job(IN1_LINE, OUT1_LINE, JOB1_LINES);
    prepare_job(IN2_LINE, OUT2_LINE, JOB2_LINES);
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;

    // Feature list and an unmapped word
    mmio_read_check(DFH_ADDR, 9'h011, DFH_VALUE);
    mmio_read_check(ID_LOW_ADDR, 9'h022, AFU_ID[63:0]);
    mmio_read_check(ID_HIGH_ADDR, 9'h133, AFU_ID[127:64]);
    mmio_read_check(RSVD0_ADDR, 9'h044, 64'd0);
    mmio_read_check(16'h0100, 9'h1f5, 64'd0);

    mmio_write(DSM_ADDR, 64'(DSM_LINE) << 6);
    run_job(IN1_LINE, OUT1_LINE, JOB1_LINES);
    // Second job, smaller and elsewhere
    run_job(IN2_LINE, OUT2_LINE, JOB2_LINES);

    prop_errors = DUT.u_props.fail_count;
    $display("error count: %0d data, %0d assertion", error_count, prop_errors);
    if (error_count == 0 && prop_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: verif/fir_props.sv
// Checks assume one job at a time and a DSM base outside both buffers
`timescale 1ns/100ps

module fir_props (
  input logic                     clk,
  input logic                     reset,
  input logic                     mmio_rd_valid,
  input fir_host_pkg::t_mmio_addr mmio_addr,
  input fir_host_pkg::t_tid       mmio_tid,
  input logic                     mmio_rsp_valid,
  input fir_host_pkg::t_tid       mmio_rsp_tid,
  input logic                     rd_req_valid,
  input fir_host_pkg::t_line_addr rd_req_addr,
  input logic                     rd_alm_full,
  input logic                     wr_req_valid,
  input fir_host_pkg::t_line_addr wr_req_addr,
  input fir_host_pkg::t_line_data wr_req_data,
  input logic                     wr_alm_full,
  input logic                     job_start,
  input fir_host_pkg::t_line_addr in_addr,
  input logic [31:0]              in_size,
  input logic [31:0]              out_size,
  input fir_host_pkg::t_line_addr dsm_base
);
  import fir_host_pkg::*;
  import fir_pkg::*;

  int          fail_count = 0;
  logic [31:0] rd_left;
  logic [31:0] wr_left;
  t_line_addr  rd_next;
  logic        dsm_seen;
  logic        dsm_write;

  assign dsm_write = wr_req_valid && (wr_req_addr == dsm_base);

  // Expected progress of the current job
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_left  <= '0;
      wr_left  <= '0;
      rd_next  <= '0;
      dsm_seen <= 1'b0;
    end else if (job_start) begin
      rd_left  <= in_size;
      wr_left  <= out_size;
      rd_next  <= in_addr;
      dsm_seen <= 1'b0;
    end else begin
      if (rd_req_valid) begin
        rd_left <= rd_left - 1'b1;
        rd_next <= rd_next + 1'b1;
      end
      if (wr_req_valid && !dsm_write)
        wr_left <= wr_left - 1'b1;
      if (dsm_write)
        dsm_seen <= 1'b1;
    end
  end

  a_reset_quiet: assert property (@(posedge clk)
    $past(reset) |-> !mmio_rsp_valid && !rd_req_valid && !wr_req_valid)
    else begin
      $error("request or response strobe high during reset or the cycle after");
      fail_count++;
    end

  a_mmio_latency: assert property (@(posedge clk) disable iff (reset)
    mmio_rsp_valid == $past(mmio_rd_valid && (mmio_addr < CSR_SPACE_LIMIT), 2))
    else begin
      $error("MMIO response not exactly two cycles after a CSR read");
      fail_count++;
    end

  a_mmio_tid: assert property (@(posedge clk) disable iff (reset)
    mmio_rsp_valid |-> mmio_rsp_tid == $past(mmio_tid, 2))
    else begin
      $error("MMIO response tid differs from the read's tid");
      fail_count++;
    end

  a_rd_hold: assert property (@(posedge clk) disable iff (reset)
    rd_alm_full |-> !rd_req_valid)
    else begin
      $error("read request issued while rd_alm_full is high");
      fail_count++;
    end

  a_wr_hold: assert property (@(posedge clk) disable iff (reset)
    wr_alm_full |-> !wr_req_valid)
    else begin
      $error("write request issued while wr_alm_full is high");
      fail_count++;
    end

  a_rd_order: assert property (@(posedge clk) disable iff (reset)
    rd_req_valid |-> (rd_left != '0) && (rd_req_addr == rd_next))
    else begin
      $error("read request outside buffer 0 or out of order");
      fail_count++;
    end

  a_result_count: assert property (@(posedge clk) disable iff (reset)
    wr_req_valid && !dsm_write |-> wr_left != '0)
    else begin
      $error("more result writes than buffer 1 holds");
      fail_count++;
    end

  // Completion write comes last and only once per job
  a_dsm_last: assert property (@(posedge clk) disable iff (reset)
    dsm_write |-> (wr_left == '0) && (rd_left == '0) && !dsm_seen
                  && (wr_req_data == DONE_WORD))
    else begin
      $error("completion write early, repeated or with the wrong value");
      fail_count++;
    end

endmodule

// File: verif/tb_clock.sv
// Free-running clock that starts low, period fixed at 20 ns
`timescale 1ns/100ps

module tb_clock #(
  parameter int HALF_PERIOD = 10
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #(HALF_PERIOD) clk = ~clk;

endmodule

// File: verilog/fir_afu.sv
// Read responses must return in request order and only one job runs at a time
`timescale 1ns/100ps

module fir_afu (
  input  logic                     clk,
  input  logic                     reset,
  // MMIO channels
  input  logic                     mmio_rd_valid,
  input  logic                     mmio_wr_valid,
  input  fir_host_pkg::t_mmio_addr mmio_addr,
  input  fir_host_pkg::t_tid       mmio_tid,
  input  fir_host_pkg::t_mmio_data mmio_wdata,
  output logic                     mmio_rsp_valid,
  output fir_host_pkg::t_tid       mmio_rsp_tid,
  output fir_host_pkg::t_mmio_data mmio_rsp_data,
  // Memory read
  output logic                     rd_req_valid,
  output fir_host_pkg::t_line_addr rd_req_addr,
  input  logic                     rd_alm_full,
  input  logic                     rd_rsp_valid,
  input  fir_host_pkg::t_line_data rd_rsp_data,
  // Memory write
  output logic                     wr_req_valid,
  output fir_host_pkg::t_line_addr wr_req_addr,
  output fir_host_pkg::t_line_data wr_req_data,
  input  logic                     wr_alm_full,
  input  logic                     wr_rsp_valid
);
  import fir_host_pkg::*;
  import fir_pkg::*;

  t_hc_control hc_control;
  t_line_addr  hc_dsm_base;
  t_hc_buffer  hc_buffer [HC_BUFFER_SIZE];

  logic       afu_rd_req_valid;
  t_line_addr afu_rd_req_addr;
  logic       afu_wr_req_valid;
  t_line_addr afu_wr_req_addr;
  t_line_data afu_wr_req_data;
  logic       afu_rd_alm_full;
  logic       afu_wr_alm_full;
  logic       afu_wr_rsp_valid;
  logic       job_start;

  logic                    in_pop;
  logic                    in_empty;
  t_line_data              in_data;
  logic [FIFO_COUNT_W-1:0] in_count;
  logic                    out_push;
  logic                    out_pop;
  logic                    out_empty;
  logic                    out_full;
  t_line_data              filt_data;
  t_line_data              out_data;

  fir_csr u_csr (
    .clk, .reset,
    .mmio_rd_valid, .mmio_wr_valid, .mmio_addr, .mmio_tid, .mmio_wdata,
    .mmio_rsp_valid, .mmio_rsp_tid, .mmio_rsp_data,
    .hc_control, .hc_dsm_base, .hc_buffer,
    .afu_rd_req_valid, .afu_rd_req_addr,
    .afu_wr_req_valid, .afu_wr_req_addr, .afu_wr_req_data,
    .afu_rd_alm_full, .afu_wr_alm_full, .afu_wr_rsp_valid,
    .rd_req_valid, .rd_req_addr,
    .wr_req_valid, .wr_req_addr, .wr_req_data,
    .rd_alm_full, .wr_alm_full, .wr_rsp_valid
  );

  fir_fetch u_fetch (
    .clk, .reset,
    .hc_control,
    .hc_buffer_in (hc_buffer[0]),
    .rd_alm_full  (afu_rd_alm_full),
    .fifo_count   (in_count),
    .rd_rsp_valid,
    .rd_req_valid (afu_rd_req_valid),
    .rd_req_addr  (afu_rd_req_addr),
    .job_start
  );

  // Read data lands here in request order
  fir_fifo #(.t_payload(t_line_data), .DEPTH(FIFO_DEPTH)) u_in_fifo (
    .clk, .reset,
    .push (rd_rsp_valid), .push_data (rd_rsp_data),
    .pop (in_pop), .pop_data (in_data),
    .empty (in_empty), .full (), .count (in_count)
  );

  fir_filter u_filter (
    .clk, .reset, .job_start,
    .in_empty, .in_data, .in_pop,
    .out_full, .out_push, .out_data (filt_data)
  );

  fir_fifo #(.t_payload(t_line_data), .DEPTH(FIFO_DEPTH)) u_out_fifo (
    .clk, .reset,
    .push (out_push), .push_data (filt_data),
    .pop (out_pop), .pop_data (out_data),
    .empty (out_empty), .full (out_full), .count ()
  );

  fir_store u_store (
    .clk, .reset, .job_start,
    .hc_buffer_out (hc_buffer[1]),
    .hc_dsm_base,
    .in_empty      (out_empty),
    .in_data       (out_data),
    .in_pop        (out_pop),
    .wr_alm_full   (afu_wr_alm_full),
    .wr_rsp_valid  (afu_wr_rsp_valid),
    .wr_req_valid  (afu_wr_req_valid),
    .wr_req_addr   (afu_wr_req_addr),
    .wr_req_data   (afu_wr_req_data)
  );

endmodule

// File: verilog/fir_store.sv
// The next job must start only after the completion write has been acknowledged
`timescale 1ns/100ps

module fir_store (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     job_start,
  input  fir_pkg::t_hc_buffer      hc_buffer_out,
  input  fir_host_pkg::t_line_addr hc_dsm_base,
  input  logic                     in_empty,
  input  fir_host_pkg::t_line_data in_data,
  output logic                     in_pop,
  input  logic                     wr_alm_full,
  input  logic                     wr_rsp_valid,
  output logic                     wr_req_valid,
  output fir_host_pkg::t_line_addr wr_req_addr,
  output fir_host_pkg::t_line_data wr_req_data
);
  import fir_host_pkg::*;
  import fir_pkg::*;

  logic        active;
  logic [31:0] wr_left;
  logic [31:0] ack_left;
  t_line_addr  line_addr;
  t_line_addr  dsm_addr;
  logic        dsm_go;

  // Result writes first, then one completion write once all acks are in
  assign in_pop = active && (wr_left != '0) && !in_empty && !wr_alm_full;
  assign dsm_go = active && (wr_left == '0) && (ack_left == '0) && !wr_alm_full;

  assign wr_req_valid = in_pop || dsm_go;
  assign wr_req_addr  = dsm_go ? dsm_addr : line_addr;
  assign wr_req_data  = dsm_go ? DONE_WORD : in_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      active   <= 1'b0;
      wr_left  <= '0;
      ack_left <= '0;
    end else if (job_start) begin
      active   <= 1'b1;
      wr_left  <= hc_buffer_out.size;
      ack_left <= hc_buffer_out.size;
    end else begin
      if (in_pop)
        wr_left <= wr_left - 1'b1;
      // The completion write's own ack finds the counter at zero
      if (wr_rsp_valid && ack_left != '0)
        ack_left <= ack_left - 1'b1;
      if (dsm_go)
        active <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (job_start) begin
      line_addr <= hc_buffer_out.address;
      dsm_addr  <= hc_dsm_base;
    end else if (in_pop) begin
      line_addr <= line_addr + 1'b1;
    end
  end

endmodule

// File: verilog/fir_filter.sv
// Four-tap FIR on four signed samples per word, results truncated to 16 bits without saturation
`timescale 1ns/100ps

module fir_filter (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     job_start,
  input  logic                     in_empty,
  input  fir_host_pkg::t_line_data in_data,
  output logic                     in_pop,
  input  logic                     out_full,
  output logic                     out_push,
  output fir_host_pkg::t_line_data out_data
);
  import fir_host_pkg::*;
  import fir_pkg::*;

  localparam int HIST   = FIR_TAPS - 1;
  localparam int WINDOW = SAMPLES_PER_LINE + HIST;

  // hist[0] is the newest sample of the previous word
  t_sample             hist [HIST];
  t_sample             window [WINDOW];
  logic signed [33:0]  acc;
  t_line_data          result;
  logic                out_valid;

  // Result register drains whenever the output FIFO has room
  assign out_push = out_valid && !out_full;
  assign in_pop   = !in_empty && (!out_valid || !out_full);

  always_comb begin
    for (int i = 0; i < HIST; i++) begin
      window[i] = hist[HIST - 1 - i];
    end
    for (int m = 0; m < SAMPLES_PER_LINE; m++) begin
      window[HIST + m] = t_sample'(in_data[16*m +: 16]);
    end
    for (int n = 0; n < SAMPLES_PER_LINE; n++) begin
      acc = '0;
      for (int k = 0; k < FIR_TAPS; k++) begin
        acc = acc + FIR_COEFF[k] * window[HIST + n - k];
      end
      result[16*n +: 16] = 16'(acc >>> FIR_SHIFT);
    end
  end

  always_ff @(posedge clk) begin
    if (reset || job_start) begin
      for (int i = 0; i < HIST; i++) begin
        hist[i] <= '0;
      end
    end else if (in_pop) begin
      for (int i = 0; i < HIST; i++) begin
        hist[i] <= window[WINDOW - 1 - i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset)
      out_valid <= 1'b0;
    else if (in_pop)
      out_valid <= 1'b1;
    else if (out_push)
      out_valid <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (in_pop)
      out_data <= result;
  end

endmodule

// File: verilog/fir_fetch.sv
// Responses must return in request order and a new run edge must wait for the previous job
`timescale 1ns/100ps

module fir_fetch (
  input  logic                                clk,
  input  logic                                reset,
  input  fir_pkg::t_hc_control                hc_control,
  input  fir_pkg::t_hc_buffer                 hc_buffer_in,
  input  logic                                rd_alm_full,
  input  logic [fir_pkg::FIFO_COUNT_W-1:0]    fifo_count,
  input  logic                                rd_rsp_valid,
  output logic                                rd_req_valid,
  output fir_host_pkg::t_line_addr            rd_req_addr,
  output logic                                job_start
);
  import fir_pkg::*;

  logic                    run_q;
  logic [31:0]             remaining;
  logic [FIFO_COUNT_W-1:0] outstanding;
  // Requests in flight plus words already queued
  logic [FIFO_COUNT_W:0]   in_flight;

  assign job_start = hc_control.run && !run_q;
  assign in_flight = outstanding + fifo_count;

  // Only issue when every response already has a FIFO slot
  assign rd_req_valid = (remaining != '0) && !rd_alm_full && (in_flight < FIFO_DEPTH);

  always_ff @(posedge clk) begin
    if (reset) begin
      run_q       <= 1'b0;
      remaining   <= '0;
      outstanding <= '0;
    end else begin
      run_q <= hc_control.run;
      if (job_start)
        remaining <= hc_buffer_in.size;
      else if (rd_req_valid)
        remaining <= remaining - 1'b1;
      if (rd_req_valid && !rd_rsp_valid)
        outstanding <= outstanding + 1'b1;
      else if (rd_rsp_valid && !rd_req_valid)
        outstanding <= outstanding - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (job_start)
      rd_req_addr <= hc_buffer_in.address;
    else if (rd_req_valid)
      rd_req_addr <= rd_req_addr + 1'b1;
  end

endmodule

// File: verilog/fir_fifo.sv
// First-word-fall-through FIFO, DEPTH a power of two, push when full and pop when empty ignored
`timescale 1ns/100ps

module fir_fifo #(
  parameter type t_payload = logic [63:0],
  parameter int  DEPTH     = 8
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         push,
  input  t_payload                     push_data,
  input  logic                         pop,
  output t_payload                     pop_data,
  output logic                         empty,
  output logic                         full,
  output logic [$clog2(DEPTH+1)-1:0]   count
);
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(DEPTH);

  t_payload         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_push;
  logic             do_pop;

  assign do_push  = push && !full;
  assign do_pop   = pop && !empty;
  assign empty    = (count == '0);
  assign full     = (count == FULL_COUNT);
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      // Simultaneous push and pop leave the count alone
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

endmodule

// File: verilog/fir_csr.sv
// Answers feature-list reads below word 0x400 and holds write-only registers with no readback
`timescale 1ns/100ps

module fir_csr (
  input  logic                     clk,
  input  logic                     reset,
  // MMIO request from the host
  input  logic                     mmio_rd_valid,
  input  logic                     mmio_wr_valid,
  input  fir_host_pkg::t_mmio_addr mmio_addr,
  input  fir_host_pkg::t_tid       mmio_tid,
  input  fir_host_pkg::t_mmio_data mmio_wdata,
  // MMIO response to the host
  output logic                     mmio_rsp_valid,
  output fir_host_pkg::t_tid       mmio_rsp_tid,
  output fir_host_pkg::t_mmio_data mmio_rsp_data,
  // Configuration
  output fir_pkg::t_hc_control     hc_control,
  output fir_host_pkg::t_line_addr hc_dsm_base,
  output fir_pkg::t_hc_buffer      hc_buffer [fir_pkg::HC_BUFFER_SIZE],
  // Accelerator side of the memory channels
  input  logic                     afu_rd_req_valid,
  input  fir_host_pkg::t_line_addr afu_rd_req_addr,
  input  logic                     afu_wr_req_valid,
  input  fir_host_pkg::t_line_addr afu_wr_req_addr,
  input  fir_host_pkg::t_line_data afu_wr_req_data,
  output logic                     afu_rd_alm_full,
  output logic                     afu_wr_alm_full,
  output logic                     afu_wr_rsp_valid,
  // Host side of the memory channels
  output logic                     rd_req_valid,
  output fir_host_pkg::t_line_addr rd_req_addr,
  output logic                     wr_req_valid,
  output fir_host_pkg::t_line_addr wr_req_addr,
  output fir_host_pkg::t_line_data wr_req_data,
  input  logic                     rd_alm_full,
  input  logic                     wr_alm_full,
  input  logic                     wr_rsp_valid
);
  import fir_host_pkg::*;
  import fir_pkg::*;

  // Registered MMIO request
  logic       req_rd_valid;
  logic       req_wr_valid;
  t_mmio_addr req_addr;
  t_tid       req_tid;
  t_mmio_data req_wdata;

  logic is_csr_read;

  // Memory channels cross unchanged
  assign rd_req_valid     = afu_rd_req_valid;
  assign rd_req_addr      = afu_rd_req_addr;
  assign wr_req_valid     = afu_wr_req_valid;
  assign wr_req_addr      = afu_wr_req_addr;
  assign wr_req_data      = afu_wr_req_data;
  assign afu_rd_alm_full  = rd_alm_full;
  assign afu_wr_alm_full  = wr_alm_full;
  assign afu_wr_rsp_valid = wr_rsp_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      req_rd_valid <= 1'b0;
      req_wr_valid <= 1'b0;
    end else begin
      req_rd_valid <= mmio_rd_valid;
      req_wr_valid <= mmio_wr_valid;
    end
  end

  always_ff @(posedge clk) begin
    req_addr  <= mmio_addr;
    req_tid   <= mmio_tid;
    req_wdata <= mmio_wdata;
  end

  assign is_csr_read = req_rd_valid && (req_addr < CSR_SPACE_LIMIT);

  // Feature-list response, second cycle after the read
  always_ff @(posedge clk) begin
    if (reset) begin
      mmio_rsp_valid <= 1'b0;
    end else begin
      mmio_rsp_valid <= is_csr_read;
    end
  end

  always_ff @(posedge clk) begin
    mmio_rsp_tid <= req_tid;
    case (req_addr)
      DFH_ADDR:               mmio_rsp_data <= DFH_VALUE;
      ID_LOW_ADDR:            mmio_rsp_data <= AFU_ID[63:0];
      ID_HIGH_ADDR:           mmio_rsp_data <= AFU_ID[127:64];
      RSVD0_ADDR, RSVD1_ADDR: mmio_rsp_data <= '0;
      default:                mmio_rsp_data <= '0;
    endcase
  end

  // Byte addresses and sizes are kept in lines
  always_ff @(posedge clk) begin
    if (reset) begin
      hc_control  <= '0;
      hc_dsm_base <= '0;
      for (int i = 0; i < HC_BUFFER_SIZE; i++) begin
        hc_buffer[i] <= '0;
      end
    end else if (req_wr_valid) begin
      if (req_addr == DSM_ADDR)
        hc_dsm_base <= t_line_addr'(req_wdata >> 6);
      if (req_addr == CONTROL_ADDR)
        hc_control <= t_hc_control'(req_wdata[31:0]);
      for (int i = 0; i < HC_BUFFER_SIZE; i++) begin
        if (req_addr == BUFFER_ADDR_BASE + t_mmio_addr'(4 * i))
          hc_buffer[i].address <= t_line_addr'(req_wdata >> 6);
        if (req_addr == BUFFER_ADDR_BASE + t_mmio_addr'(4 * i + 2))
          hc_buffer[i].size <= 32'(req_wdata >> 6);
      end
    end
  end

endmodule

// File: verilog/fir_pkg.sv
// Filter job types for two buffers only, buffer 0 input and buffer 1 output
package fir_pkg;

  localparam int HC_BUFFER_SIZE = 2;

  // Only bit 0 of the control word is used
  typedef struct packed {
    logic [30:0] rsvd;
    logic        run;
  } t_hc_control;

  // Address and size both in lines
  typedef struct packed {
    fir_host_pkg::t_line_addr address;
    logic [31:0]              size;
  } t_hc_buffer;

  typedef logic signed [15:0] t_sample;

  localparam int SAMPLES_PER_LINE = 4;
  localparam int FIR_TAPS         = 4;

  // Tap k weights the sample k positions back, unity gain after the shift
  localparam t_sample FIR_COEFF [FIR_TAPS] = '{16'sd96, 16'sd80, 16'sd48, 16'sd32};
  localparam int      FIR_SHIFT            = 8;

  localparam fir_host_pkg::t_line_data DONE_WORD = 64'd1;

  // Both data FIFOs
  localparam int FIFO_DEPTH   = 8;
  localparam int FIFO_COUNT_W = $clog2(FIFO_DEPTH + 1);

endpackage

// File: verilog/fir_host_pkg.sv
// Host link widths and MMIO word addresses for a line narrowed to one 64-bit word
package fir_host_pkg;

  // Channel payload types
  typedef logic [15:0] t_mmio_addr;
  typedef logic [63:0] t_mmio_data;
  typedef logic [8:0]  t_tid;
  typedef logic [41:0] t_line_addr;
  typedef logic [63:0] t_line_data;

  // Reads below this word address belong to the CSR block
  localparam t_mmio_addr CSR_SPACE_LIMIT = 16'h0400;

  // Device feature header and accelerator ID
  localparam logic [63:0]  DFH_VALUE = 64'h1000_0000_1000_0000;
  localparam logic [127:0] AFU_ID    = 128'hC000C966_0D82_4272_9AEF_FE5F84570612;

  // Read-only feature list, in 32-bit word units
  localparam t_mmio_addr DFH_ADDR     = 16'h0000;
  localparam t_mmio_addr ID_LOW_ADDR  = 16'h0002;
  localparam t_mmio_addr ID_HIGH_ADDR = 16'h0004;
  localparam t_mmio_addr RSVD0_ADDR   = 16'h0006;
  localparam t_mmio_addr RSVD1_ADDR   = 16'h0008;

  // Writable registers
  localparam t_mmio_addr DSM_ADDR     = 16'h0020;
  localparam t_mmio_addr CONTROL_ADDR = 16'h0024;
  // Buffer i address at base + 4i, its size 2 words above
  localparam t_mmio_addr BUFFER_ADDR_BASE = 16'h0030;

endpackage
